// File: bench/exec_checker.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module exec_checker (
    input  logic             clk,
    input  logic             reset,
    input  logic             op_valid,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::word_t   a,
    input  alu_pkg::word_t   b,
    input  logic             result_valid,
    input  alu_pkg::word_t   result,
    input  alu_pkg::comp_t   comp,
    input  logic             busy,
    output int               errors,
    output int               checked
);
    import alu_pkg::*;

    localparam int MAX_VEC = 64;

    logic [3:0] exp_op   [MAX_VEC];
    word_t      exp_a    [MAX_VEC];
    word_t      exp_b    [MAX_VEC];
    word_t      exp_res  [MAX_VEC];
    comp_t      exp_comp [MAX_VEC];
    int         n_vec;
    int         issued;       // Next data line to be issued
    int         cur;          // Line whose result is awaited
    int         cycle;        // Edges since reset release
    int         due;          // Edge where result_valid must be sampled
    logic       pending;
    logic       pending_div;  // Divide in flight, busy expected

    // Own copy of the expected values
    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_comp;
        word_t       f_a;
        word_t       f_b;
        word_t       f_res;
        n_vec = 0;
        fd = $fopen("bench/exec_testdata.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) > 0) begin
                n = $sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_comp);
                if (n == 5 && n_vec < MAX_VEC) begin  // Comment lines do not parse
                    exp_op[n_vec]   = f_op[3:0];
                    exp_a[n_vec]    = f_a;
                    exp_b[n_vec]    = f_b;
                    exp_res[n_vec]  = f_res;
                    exp_comp[n_vec] = f_comp[1:0];
                    n_vec++;
                end
            end
            $fclose(fd);
        end
    end

    task automatic compare_result();
        if (result !== exp_res[cur]) begin
            $display("Mismatch result line %0d: expected %h, got %h", cur, exp_res[cur], result);
            errors++;
        end
        if (comp !== exp_comp[cur]) begin
            $display("Mismatch comp line %0d: expected %h, got %h", cur, exp_comp[cur], comp);
            errors++;
        end
        checked++;
    endtask

    // Samples at the edge, so DUT outputs are the values registered one edge earlier
    always @(posedge clk) begin
        if (reset) begin
            errors      = 0;
            checked     = 0;
            issued      = 0;
            cur         = 0;
            cycle       = 0;
            due         = 0;
            pending     = 1'b0;
            pending_div = 1'b0;
        end else begin
            cycle++;
            if (busy !== pending_div) begin
                $display("Mismatch busy at cycle %0d: expected %h, got %h",
                         cycle, pending_div, busy);
                errors++;
            end
            if (result_valid || (pending && cycle == due)) begin
                if (result_valid && pending && cycle == due) begin
                    compare_result();
                end else if (result_valid) begin
                    $display("result_valid pulsed at cycle %0d with no result due", cycle);
                    errors++;
                end else begin
                    $display("result_valid missing at cycle %0d for line %0d", cycle, cur);
                    errors++;
                end
                pending     = 1'b0;
                pending_div = 1'b0;
            end
            if (op_valid) begin
                if (issued >= n_vec) begin
                    $display("op_valid seen after the last line of test data");
                    errors++;
                end else begin
                    if (op !== exp_op[issued] || a !== exp_a[issued] || b !== exp_b[issued]) begin
                        $display("Operation issued as line %0d differs from the data", issued);
                        errors++;
                    end
                    cur         = issued;
                    pending     = 1'b1;
                    pending_div = op inside {OP_DIV, OP_MOD, OP_DIVU, OP_MODU};
                    // Registered latency edges on, sampled one edge after that
                    due = cycle + (pending_div ? `DIV_LATENCY : 1) + 1;
                end
                issued++;
            end
        end
    end

endmodule

// File: bench/exec_testdata.txt
// op a b result comp, all hex, one operation per line
// comp 0 equal, 1 a less than b, 2 a greater than b (signed)
0 7fffffff 00000001 80000000 2
0 ffffffff 00000001 00000000 1
1 00000003 00000005 fffffffe 1
1 80000000 00000001 7fffffff 1
2 f0f0f0f0 0ff00ff0 00f000f0 1
3 12345678 12345678 12345678 0
4 aaaaaaaa 55555555 ffffffff 1
5 00000001 0000001f 80000000 1
5 12345678 00000000 12345678 2
5 00000003 00000024 00000030 1
6 80000000 0000001f 00000001 1
7 80000000 0000001f ffffffff 1
7 f0000000 00000024 ff000000 1
7 40000000 00000021 20000000 2
8 fffffffe 00000003 fffffffa 1
9 fffffffe 00000003 ffffffff 1
9 80000000 80000000 40000000 0
9 7fffffff 80000000 c0000000 2
a ffffffff ffffffff 00000001 0
b ffffffff ffffffff fffffffe 0
c fffffff9 00000002 fffffffd 1
d 00000007 fffffffe 00000001 2
e fffffff9 00000002 7ffffffc 1
f 00000064 00000007 00000002 2
c 00001234 00000000 ffffffff 2
d 00001234 00000000 00001234 2
c 80000000 ffffffff 80000000 1
d 80000000 ffffffff 00000000 1

// File: bench/tb_exec_unit.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module tb_exec_unit;
    import alu_pkg::*;

    localparam int MAX_VEC = 64;

    logic       clk;
    logic       reset;
    logic       op_valid;
    alu_op_t    op;
    word_t      a;
    word_t      b;
    logic       result_valid;
    word_t      result;
    comp_t      comp;
    logic       busy;
    int         checker_errors;
    int         results_seen;
    int         bench_errors;
    int         n_vec;
    logic       loaded;      // Vector count known, watchdog may start
    integer     seed;
    logic [3:0] vec_op [MAX_VEC];
    word_t      vec_a  [MAX_VEC];
    word_t      vec_b  [MAX_VEC];

    exec_unit i_exec_unit (
        .clk          (clk),
        .reset        (reset),
        .op_valid     (op_valid),
        .op           (op),
        .a            (a),
        .b            (b),
        .result_valid (result_valid),
        .result       (result),
        .comp         (comp),
        .busy         (busy)
    );

    exec_checker i_checker (
        .clk          (clk),
        .reset        (reset),
        .op_valid     (op_valid),
        .op           (op),
        .a            (a),
        .b            (b),
        .result_valid (result_valid),
        .result       (result),
        .comp         (comp),
        .busy         (busy),
        .errors       (checker_errors),
        .checked      (results_seen)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    // Operands only, the checker keeps the expected side
    task automatic load_vectors();
        int          fd;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_res;
        logic [31:0] f_comp;
        word_t       f_a;
        word_t       f_b;
        fd = $fopen("bench/exec_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open bench/exec_testdata.txt");
            bench_errors++;
        end else begin
            while ($fgets(line, fd) > 0) begin
                if ($sscanf(line, "%h %h %h %h %h", f_op, f_a, f_b, f_res, f_comp) == 5
                    && n_vec < MAX_VEC) begin
                    vec_op[n_vec] = f_op[3:0];
                    vec_a[n_vec]  = f_a;
                    vec_b[n_vec]  = f_b;
                    n_vec++;
                end
            end
            $fclose(fd);
        end
    endtask

    // Entered and left 2 ns after a rising edge
    task automatic run_op(input int idx);
        int idle;
        op_valid = 1'b1;
        op       = alu_op_t'(vec_op[idx]);
        a        = vec_a[idx];
        b        = vec_b[idx];
        @(posedge clk);
        #2 op_valid = 1'b0;
        while (!result_valid) begin
            @(posedge clk);
            #2;
        end
        while (busy) begin  // Still up in the result cycle of a divide
            @(posedge clk);
            #2;
        end
        idle = $unsigned($random(seed)) % 4;
        repeat (idle) begin
            @(posedge clk);
            #2;
        end
    endtask

    initial begin
        seed         = 32'hba5e_d65a;
        reset        = 1'b1;
        op_valid     = 1'b0;
        op           = OP_ADD;
        a            = '0;
        b            = '0;
        bench_errors = 0;
        n_vec        = 0;
        loaded       = 1'b0;
        load_vectors();
        loaded = 1'b1;
        repeat (10) @(posedge clk);
        #2 reset = 1'b0;
        repeat (3) begin  // Idle after reset, no result_valid allowed
            @(posedge clk);
            #2;
        end
        for (int i = 0; i < n_vec; i++) begin
            run_op(i);
        end
        repeat (4) begin  // Checker settles on each edge before the counts are read
            @(posedge clk);
            #2;
        end
        if (results_seen != n_vec) begin
            $display("Only %0d of %0d operations were checked", results_seen, n_vec);
            bench_errors++;
        end
        $display("Errors: %0d checker, %0d bench, %0d results checked",
                 checker_errors, bench_errors, results_seen);
        if (checker_errors == 0 && bench_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Every line may be a full divide plus a few idle cycles
    initial begin
        int limit;
        wait (loaded);
        limit = n_vec * (`DIV_LATENCY + 4) + 20;
        repeat (limit) @(posedge clk);
        $display("Timeout: no end of test after %0d clock cycles", limit);
        $display("Test FAILED");
        $finish;
    end

endmodule

// File: run.sh
#!/bin/sh
# Compile with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_exec_unit \
    > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_exec_unit > sim.log 2>&1
cat sim.log
grep -q "Test OK" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: source/alu.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module alu (
    input  alu_pkg::word_t   a,
    input  alu_pkg::word_t   b,
    input  alu_pkg::alu_op_t op,
    output alu_pkg::word_t   result,
    output alu_pkg::comp_t   comp
);
    import alu_pkg::*;

    logic [2*`WORD_W-1:0]     prod_u;  // Full unsigned product
    logic [2*`WORD_W-1:0]     prod_s;  // Full two's-complement product
    logic [$clog2(`WORD_W)-1:0] shamt;   // Shift amount

    // Low bits of b only, anything above 31 wraps
    assign shamt = b[$clog2(`WORD_W)-1:0];

    // Both products every cycle, the opcode only picks a word
    always_comb begin
        prod_u = {{`WORD_W{1'b0}}, a} * {{`WORD_W{1'b0}}, b};
        // Sign extend to full width first, low 64 bits are exact
        prod_s = {{`WORD_W{a[`WORD_W-1]}}, a} * {{`WORD_W{b[`WORD_W-1]}}, b};
    end

    // Signed compare goes out with every result
    always_comb begin
        if ($signed(a) == $signed(b)) begin
            comp = 2'b00;
        end else if ($signed(a) < $signed(b)) begin
            comp = 2'b01;
        end else begin
            comp = 2'b10;  // Greater
        end
    end

    always_comb begin
        case (op)
            OP_ADD: begin
                result = a + b;  // Wraps modulo 2^32
            end
            OP_SUB: begin
                result = a - b;
            end
            OP_AND: begin
                result = a & b;
            end
            OP_OR: begin
                result = a | b;
            end
            OP_XOR: begin
                result = a ^ b;
            end
            OP_SLL: begin
                result = a << shamt;
            end
            OP_SRL: begin
                result = a >> shamt;  // Zero fill
            end
            OP_SRA: begin
                result = $signed(a) >>> shamt;  // Sign fill
            end
            OP_MULT_LO: begin
                result = prod_s[`WORD_W-1:0];
            end
            OP_MULT_HI: begin
                result = prod_s[2*`WORD_W-1:`WORD_W];
            end
            OP_MULTU_LO: begin
                result = prod_u[`WORD_W-1:0];
            end
            OP_MULTU_HI: begin
                result = prod_u[2*`WORD_W-1:`WORD_W];
            end
            // Divide class comes from the divider, top level muxes it in
            OP_DIV, OP_MOD, OP_DIVU, OP_MODU: begin
                result = '0;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: source/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Datapath word, fixed by the ISA
`define WORD_W 32

// Opcode field, sixteen operations
`define OP_W 4

// Cycles from op_valid to result_valid for DIV, MOD, DIVU and MODU
// Issue register 1, divider load with first step 1,
// remaining 31 iterations, sign fix 1
`define DIV_LATENCY 34

`endif

// File: source/alu_pkg.sv
`include "alu_macros.svh"

package alu_pkg;

    // One data word, used for operands, results and divider state
    typedef logic [`WORD_W-1:0] word_t;

    // Opcode encoding as used by the decoder
    typedef enum logic [`OP_W-1:0] {
        OP_ADD      = 4'd0,
        OP_SUB      = 4'd1,
        OP_AND      = 4'd2,
        OP_OR       = 4'd3,
        OP_XOR      = 4'd4,
        OP_SLL      = 4'd5,
        OP_SRL      = 4'd6,
        OP_SRA      = 4'd7,   // Arithmetic, sign fills
        OP_MULT_LO  = 4'd8,   // Signed product, low word
        OP_MULT_HI  = 4'd9,   // Signed product, high word
        OP_MULTU_LO = 4'd10,
        OP_MULTU_HI = 4'd11,
        OP_DIV      = 4'd12,  // Divide class from here up
        OP_MOD      = 4'd13,
        OP_DIVU     = 4'd14,
        OP_MODU     = 4'd15
    } alu_op_t;

    // Signed compare of a against b
    // 2'b00 equal, 2'b01 a less, 2'b10 a greater; 2'b11 never driven
    typedef logic [1:0] comp_t;

    // Divider sequencing
    typedef enum logic [1:0] {
        IDLE,  // Waiting for start
        LOAD,  // Magnitudes in, first step
        ITER,  // Remaining shift-subtract steps
        FIX    // Sign correction, done high
    } div_state_t;

endpackage

// File: source/div.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module div (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    input  logic           signed_div,
    input  alu_pkg::word_t dividend,   // Held stable by the issue register
    input  alu_pkg::word_t divisor,
    output alu_pkg::word_t quotient,
    output alu_pkg::word_t remainder,
    output logic           done
);
    import alu_pkg::*;

    div_state_t      state;
    logic [4:0]      cnt;        // Index of the step being taken
    logic            sgn_q;      // Signed request
    logic            neg_quo;    // Quotient needs negation
    logic            neg_rem;    // Remainder follows the dividend sign
    logic            dvs_zero;
    word_t           quo_q;      // Dividend bits shift out, quotient bits in
    word_t           rem_q;      // Partial remainder
    word_t           dvs_q;      // Divisor magnitude
    word_t           mag_a;
    word_t           mag_b;
    word_t           step_quo;
    word_t           step_rem;
    word_t           step_dvs;
    logic [`WORD_W:0] rem_shift; // One extra bit for the trial subtract
    logic [`WORD_W:0] trial;
    word_t           next_quo;
    word_t           next_rem;

    // Magnitudes only when signed, MIN stays MIN which is its unsigned magnitude
    assign mag_a = (sgn_q && dividend[`WORD_W-1]) ? -dividend : dividend;
    assign mag_b = (sgn_q && divisor[`WORD_W-1]) ? -divisor : divisor;

    // One restoring step, fed from the ports in LOAD and from registers after
    always_comb begin
        step_rem  = (state == LOAD) ? '0 : rem_q;
        step_quo  = (state == LOAD) ? mag_a : quo_q;
        step_dvs  = (state == LOAD) ? mag_b : dvs_q;
        rem_shift = {step_rem, step_quo[`WORD_W-1]};
        trial     = rem_shift - {1'b0, step_dvs};
        if (!trial[`WORD_W]) begin
            next_rem = trial[`WORD_W-1:0];     // Subtract fits, quotient bit 1
            next_quo = {step_quo[`WORD_W-2:0], 1'b1};
        end else begin
            next_rem = rem_shift[`WORD_W-1:0]; // Restore
            next_quo = {step_quo[`WORD_W-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE: if (start) state <= LOAD;
                LOAD: begin
                    state <= ITER;
                    cnt   <= 5'd1;  // Step 0 taken on the way out of LOAD
                end
                ITER: begin
                    cnt <= cnt + 5'd1;
                    if (cnt == 5'd31) state <= FIX;  // Last of 32 steps
                end
                default: state <= IDLE;  // FIX lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && start) sgn_q <= signed_div;
        if (state == LOAD) begin
            dvs_q    <= mag_b;
            dvs_zero <= (divisor == '0);
            neg_quo  <= sgn_q & (dividend[`WORD_W-1] ^ divisor[`WORD_W-1]);
            neg_rem  <= sgn_q & dividend[`WORD_W-1];
        end
        if (state == LOAD || state == ITER) begin
            quo_q <= next_quo;
            rem_q <= next_rem;
        end
    end

    // Sign fix in FIX, results valid only while done is high
    // Zero divisor leaves rem_q equal to |a|, so the remainder comes back as a
    assign quotient  = dvs_zero ? '1 : (neg_quo ? -quo_q : quo_q);
    assign remainder = neg_rem ? -rem_q : rem_q;
    assign done      = (state == FIX);

    // Top level must hold off start until the previous division is through
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        start |-> state == IDLE)
        else $error("div start while busy");

    // Done only 33 cycles after a start, so one start gives one single-cycle done
    a_done_pulse: assert property (@(posedge clk) disable iff (reset)
        done |-> $past(start, 33))
        else $error("div done without a start 33 cycles earlier");

endmodule

// File: source/exec_unit.sv
`timescale 1ns/1ps
`include "alu_macros.svh"

module exec_unit (
    input  logic             clk,
    input  logic             reset,
    input  logic             op_valid,
    input  alu_pkg::alu_op_t op,
    input  alu_pkg::word_t   a,
    input  alu_pkg::word_t   b,
    output logic             result_valid,
    output alu_pkg::word_t   result,
    output alu_pkg::comp_t   comp,
    output logic             busy
);
    import alu_pkg::*;

    logic    accept;      // Request taken this cycle
    logic    iss_valid;   // Issue register holds a fresh op
    alu_op_t iss_op;
    word_t   iss_a;
    word_t   iss_b;
    logic    iss_is_div;
    logic    start;
    word_t   alu_result;
    comp_t   alu_comp;
    word_t   quotient;
    word_t   remainder;
    logic    div_done;

    function automatic logic is_div_op(alu_op_t o);
        return o inside {OP_DIV, OP_MOD, OP_DIVU, OP_MODU};
    endfunction

    assign accept     = op_valid & ~busy;   // Requests during busy are dropped
    assign iss_is_div = is_div_op(iss_op);
    assign start      = iss_valid & iss_is_div;  // Divider is idle whenever busy was low

    alu i_alu (
        .a      (iss_a),
        .b      (iss_b),
        .op     (iss_op),
        .result (alu_result),
        .comp   (alu_comp)
    );

    div i_div (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .signed_div (iss_op == OP_DIV || iss_op == OP_MOD),
        .dividend   (iss_a),
        .divisor    (iss_b),
        .quotient   (quotient),
        .remainder  (remainder),
        .done       (div_done)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            iss_valid    <= 1'b0;
            result_valid <= 1'b0;
            busy         <= 1'b0;
        end else begin
            iss_valid    <= accept;
            result_valid <= (iss_valid & ~iss_is_div) | div_done;
            if (result_valid) busy <= 1'b0;  // Stays up through the result cycle
            if (accept && is_div_op(op)) busy <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            iss_op <= op;
            iss_a  <= a;
            iss_b  <= b;
        end
        if ((iss_valid && !iss_is_div) || div_done) begin
            if (div_done) begin
                result <= (iss_op == OP_MOD || iss_op == OP_MODU) ? remainder : quotient;
            end else begin
                result <= alu_result;
            end
            comp <= alu_comp;  // Operands still held for divides
        end
    end

    a_no_issue_busy: assert property (@(posedge clk) disable iff (reset)
        op_valid |-> !busy)
        else $error("op_valid raised while busy");

    // Divide class lands exactly DIV_LATENCY after op_valid
    a_div_latency: assert property (@(posedge clk) disable iff (reset)
        (iss_valid && iss_is_div) |-> ##(`DIV_LATENCY) result_valid)
        else $error("divide result late or early");

endmodule

// File: tb.f
+incdir+source
source/alu_pkg.sv
source/alu.sv
source/div.sv
source/exec_unit.sv
bench/exec_checker.sv
bench/tb_exec_unit.sv
